// ==== filelist.f ====
rtl/group_pkg.sv
rtl/tcdm_addr_decode.sv
rtl/local_interco.sv
rtl/tcdm_bank.sv
rtl/resp_route.sv
rtl/tcdm_group.sv
sim/tb_tcdm_group.sv

// ==== rtl/group_pkg.sv ====
/*
 * Tile group constants, address field positions and shared types
 */
`default_nettype none

package group_pkg;

  // ------------------------------
  // Counts
  // ------------------------------
  localparam int unsigned NumTiles     = 4;
  localparam int unsigned NumCorePorts = 4;
  // DMA sits on the highest initiator index
  localparam int unsigned NumInit      = NumCorePorts + 1;
  localparam int unsigned DmaIdx       = NumInit - 1;
  localparam int unsigned BankRows     = 64;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned AddrWidth = 12;
  localparam int unsigned IniBits   = $clog2(NumInit);

  // Byte address layout, low end first
  localparam int unsigned ByteOffBits = 2;
  localparam int unsigned TileBits    = $clog2(NumTiles);
  localparam int unsigned GroupBits   = 2;
  localparam int unsigned RowBits     = 6;
  localparam int unsigned GroupLsb    = ByteOffBits + TileBits;
  localparam int unsigned RowLsb      = GroupLsb + GroupBits;

  typedef logic [TileBits-1:0]  tile_idx_t;
  typedef logic [RowBits-1:0]   row_t;
  typedef logic [IniBits-1:0]   ini_idx_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [AddrWidth-1:0] addr_t;

  typedef enum logic {
    TCDM_READ  = 1'b0,
    TCDM_WRITE = 1'b1
  } tcdm_op_e;

endpackage

`default_nettype wire

// ==== rtl/local_interco.sv ====
/*
 * Local interconnect with one round-robin arbiter per tile,
 * driving bank strobes and initiator grants
 */
`default_nettype none

module local_interco
  import group_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Initiator side
  input  logic [NumInit-1:0]    req_valid_i,
  input  tile_idx_t             tile_i [NumInit],
  input  row_t                  row_i [NumInit],
  input  tcdm_op_e              op_i [NumInit],
  input  data_t                 wdata_i [NumInit],
  input  strb_t                 strb_i [NumInit],
  input  logic [NumInit-1:0]    slot_free_i,
  output logic [NumInit-1:0]    req_ready_o,
  output logic [NumInit-1:0]    rd_issue_o,
  // Bank side
  output logic [NumTiles-1:0]   bank_req_o,
  output tcdm_op_e              bank_op_o [NumTiles],
  output row_t                  bank_row_o [NumTiles],
  output data_t                 bank_wdata_o [NumTiles],
  output strb_t                 bank_strb_o [NumTiles],
  output ini_idx_t              bank_ini_o [NumTiles]
);

  logic [NumInit-1:0] gnt [NumTiles];

  // ------------------------------
  // Per-tile arbitration
  // ------------------------------
  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile
    logic [NumInit-1:0] elig;
    ini_idx_t           rr_q;
    ini_idx_t           winner;
    logic               found;

    // Only initiators without an open read may compete
    always_comb begin
      for (int i = 0; i < NumInit; i++) begin
        elig[i] = req_valid_i[i] && (tile_i[i] == tile_idx_t'(t)) && slot_free_i[i];
      end
    end

    // First eligible initiator at or after the pointer
    always_comb begin
      int unsigned cand;
      found  = 1'b0;
      winner = rr_q;
      for (int unsigned k = 0; k < NumInit; k++) begin
        cand = rr_q + k;
        if (cand >= NumInit) begin
          cand = cand - NumInit;
        end
        if (!found && elig[cand]) begin
          found  = 1'b1;
          winner = ini_idx_t'(cand);
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rr_q <= '0;
      end else if (found) begin
        rr_q <= (winner == ini_idx_t'(NumInit - 1)) ? '0 : winner + 1'b1;
      end
    end

    assign gnt[t] = found ? (NumInit'(1) << winner) : '0;

    assign bank_req_o[t]   = found;
    assign bank_op_o[t]    = op_i[winner];
    assign bank_row_o[t]   = row_i[winner];
    assign bank_wdata_o[t] = wdata_i[winner];
    assign bank_strb_o[t]  = strb_i[winner];
    assign bank_ini_o[t]   = winner;
  end

  // ------------------------------
  // Grant collection
  // ------------------------------
  always_comb begin
    req_ready_o = '0;
    for (int t = 0; t < NumTiles; t++) begin
      req_ready_o = req_ready_o | gnt[t];
    end
  end

  // A granted read opens the initiator's response slot
  always_comb begin
    for (int i = 0; i < NumInit; i++) begin
      rd_issue_o[i] = req_ready_o[i] && (op_i[i] == TCDM_READ);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/resp_route.sv ====
/*
 * Response return with one slot per initiator, loaded from the bank
 * that carries the initiator's index
 */
`default_nettype none

module resp_route
  import group_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NumInit-1:0]  rd_issue_i,
  // Bank read returns
  input  logic [NumTiles-1:0] rd_valid_i,
  input  data_t               rd_data_i [NumTiles],
  input  ini_idx_t            rd_ini_i [NumTiles],
  // Initiator response ports
  input  logic [NumInit-1:0]  resp_ready_i,
  output logic [NumInit-1:0]  resp_valid_o,
  output data_t               resp_rdata_o [NumInit],
  output logic [NumInit-1:0]  slot_free_o
);

  for (genvar i = 0; i < NumInit; i++) begin : gen_slot
    logic  hit;
    data_t hit_data;
    logic  pend_q;
    logic  held_q;
    data_t data_q;

    // At most one bank returns for a given initiator
    always_comb begin
      hit      = 1'b0;
      hit_data = rd_data_i[0];
      for (int t = 0; t < NumTiles; t++) begin
        if (rd_valid_i[t] && (rd_ini_i[t] == ini_idx_t'(i))) begin
          hit      = 1'b1;
          hit_data = rd_data_i[t];
        end
      end
    end

    // ------------------------------
    // Slot state
    // ------------------------------
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        pend_q <= 1'b0;
        held_q <= 1'b0;
      end else begin
        if (rd_issue_i[i]) begin
          pend_q <= 1'b1;
        end else if (hit) begin
          pend_q <= 1'b0;
        end
        if (hit) begin
          held_q <= 1'b1;
        end else if (held_q && resp_ready_i[i]) begin
          held_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (hit) begin
        data_q <= hit_data;
      end
    end

    assign resp_valid_o[i] = held_q;
    assign resp_rdata_o[i] = data_q;
    assign slot_free_o[i]  = !pend_q && !held_q;
  end

endmodule

`default_nettype wire

// ==== rtl/tcdm_addr_decode.sv ====
/*
 * Byte address split into target tile and bank row,
 * with the optional DMA tile remap
 */
`default_nettype none

module tcdm_addr_decode
  import group_pkg::*;
#(
  parameter bit RemapTile = 1'b0
) (
  input  addr_t     addr_i,
  output tile_idx_t tile_o,
  output row_t      row_o
);

  // ------------------------------
  // Field extraction
  // ------------------------------
  tile_idx_t                tile_field;
  logic      [GroupBits-1:0] group_field;

  assign tile_field  = addr_i[ByteOffBits +: TileBits];
  assign group_field = addr_i[GroupLsb +: GroupBits];

  // Row sits above the group field
  assign row_o = addr_i[RowLsb +: RowBits];

  // ------------------------------
  // Tile select
  // ------------------------------
  if (RemapTile) begin : gen_remap
    tile_idx_t group_tile;

    // Group field folded onto the tile index width
    assign group_tile = tile_idx_t'(group_field);

    // Wraps modulo NumTiles through the tile index width
    assign tile_o = tile_field + group_tile;
  end else begin : gen_plain
    // Cores ignore the group field
    assign tile_o = tile_field;
  end

endmodule

`default_nettype wire

// ==== rtl/tcdm_bank.sv ====
/*
 * Single-port word bank with byte-enable writes and a registered,
 * initiator-tagged read port
 */
`default_nettype none

module tcdm_bank
  import group_pkg::*;
#(
  parameter int unsigned BankRows = group_pkg::BankRows
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     req_i,
  input  tcdm_op_e op_i,
  input  row_t     row_i,
  input  data_t    wdata_i,
  input  strb_t    strb_i,
  input  ini_idx_t ini_i,
  output logic     rd_valid_o,
  output data_t    rd_data_o,
  output ini_idx_t rd_ini_o
);

  data_t    mem_q [BankRows];
  logic     rd_valid_q;
  data_t    rd_data_q;
  ini_idx_t rd_ini_q;

  // Byte-masked write
  always_ff @(posedge clk_i) begin
    if (req_i && (op_i == TCDM_WRITE)) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && (op_i == TCDM_READ)) begin
      rd_data_q <= mem_q[row_i];
      rd_ini_q  <= ini_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= req_i && (op_i == TCDM_READ);
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;
  assign rd_ini_o   = rd_ini_q;

endmodule

`default_nettype wire

// ==== rtl/tcdm_group.sv ====
/*
 * Tile group top: address decoders, local interconnect,
 * tile banks and response routing
 */
`default_nettype none

module tcdm_group
  import group_pkg::*;
#(
  parameter int unsigned BankRows = group_pkg::BankRows
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Request ports, cores first and DMA last
  input  logic [NumInit-1:0] req_valid_i,
  output logic [NumInit-1:0] req_ready_o,
  input  addr_t              req_addr_i [NumInit],
  input  tcdm_op_e           req_op_i [NumInit],
  input  data_t              req_wdata_i [NumInit],
  input  strb_t              req_strb_i [NumInit],
  // Read responses
  output logic [NumInit-1:0] resp_valid_o,
  input  logic [NumInit-1:0] resp_ready_i,
  output data_t              resp_rdata_o [NumInit]
);

  tile_idx_t           ini_tile [NumInit];
  row_t                ini_row [NumInit];
  logic [NumInit-1:0]  slot_free;
  logic [NumInit-1:0]  rd_issue;

  logic [NumTiles-1:0] bank_req;
  tcdm_op_e            bank_op [NumTiles];
  row_t                bank_row [NumTiles];
  data_t               bank_wdata [NumTiles];
  strb_t               bank_strb [NumTiles];
  ini_idx_t            bank_ini [NumTiles];

  logic [NumTiles-1:0] rd_valid;
  data_t               rd_data [NumTiles];
  ini_idx_t            rd_ini [NumTiles];

  // ------------------------------
  // Decode
  // ------------------------------
  for (genvar i = 0; i < NumInit; i++) begin : gen_decode
    // Only the DMA port shifts its tile by the group field
    tcdm_addr_decode #(
      .RemapTile(i == DmaIdx)
    ) u_decode (
      .addr_i(req_addr_i[i]),
      .tile_o(ini_tile[i]  ),
      .row_o (ini_row[i]   )
    );
  end

  // ------------------------------
  // Arbitration and bank access
  // ------------------------------
  local_interco u_interco (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_valid_i (req_valid_i ),
    .tile_i      (ini_tile    ),
    .row_i       (ini_row     ),
    .op_i        (req_op_i    ),
    .wdata_i     (req_wdata_i ),
    .strb_i      (req_strb_i  ),
    .slot_free_i (slot_free   ),
    .req_ready_o (req_ready_o ),
    .rd_issue_o  (rd_issue    ),
    .bank_req_o  (bank_req    ),
    .bank_op_o   (bank_op     ),
    .bank_row_o  (bank_row    ),
    .bank_wdata_o(bank_wdata  ),
    .bank_strb_o (bank_strb   ),
    .bank_ini_o  (bank_ini    )
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_bank
    tcdm_bank #(
      .BankRows(BankRows)
    ) u_bank (
      .clk_i     (clk_i        ),
      .rst_i     (rst_i        ),
      .req_i     (bank_req[t]  ),
      .op_i      (bank_op[t]   ),
      .row_i     (bank_row[t]  ),
      .wdata_i   (bank_wdata[t]),
      .strb_i    (bank_strb[t] ),
      .ini_i     (bank_ini[t]  ),
      .rd_valid_o(rd_valid[t]  ),
      .rd_data_o (rd_data[t]   ),
      .rd_ini_o  (rd_ini[t]    )
    );
  end

  // ------------------------------
  // Response return
  // ------------------------------
  resp_route u_resp (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .rd_issue_i  (rd_issue    ),
    .rd_valid_i  (rd_valid    ),
    .rd_data_i   (rd_data     ),
    .rd_ini_i    (rd_ini      ),
    .resp_ready_i(resp_ready_i),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o),
    .slot_free_o (slot_free   )
  );

endmodule

`default_nettype wire

// ==== sim/tb_tcdm_group.sv ====
/*
 * Testbench for the tile group: clock, reset, directed and random traffic,
 * reference memory model and response checks
 */
`default_nettype none

module tb_tcdm_group;
  import group_pkg::*;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int AcceptTimeout = 400;
  localparam int IdleTimeout   = 100;

  logic clk;
  logic rst;
  logic [NumInit-1:0] req_valid;
  logic [NumInit-1:0] req_ready;
  addr_t              req_addr [NumInit];
  tcdm_op_e           req_op [NumInit];
  data_t              req_wdata [NumInit];
  strb_t              req_strb [NumInit];
  logic [NumInit-1:0] resp_valid;
  logic [NumInit-1:0] resp_ready;
  data_t              resp_rdata [NumInit];

  // Stimulus controls
  logic [NumInit-1:0] stall_mask;
  logic               random_stall;
  logic [31:0]        rng_state = 32'h009f_8310;

  // Reference model, unwritten bits stay X
  data_t              model_mem [NumTiles][BankRows];
  logic [NumInit-1:0] m_pend;
  logic [NumInit-1:0] m_held;
  int                 acc_cycle [NumInit];
  data_t              exp_rdata [NumInit];
  data_t              seen_rdata [NumInit];
  int                 cycle;
  int                 rst_edges;

  tcdm_group #(
    .BankRows(BankRows)
  ) u_dut (
    .clk_i       (clk       ),
    .rst_i       (rst       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_addr_i  (req_addr  ),
    .req_op_i    (req_op    ),
    .req_wdata_i (req_wdata ),
    .req_strb_i  (req_strb  ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic addr_t make_addr(logic [5:0] row, logic [1:0] grp, logic [1:0] tile);
    return {row, grp, tile, 2'b00};
  endfunction

  // Tile field, plus the group field for the DMA port
  function automatic tile_idx_t model_tile(int ini, addr_t a);
    tile_idx_t t;
    t = a[3:2];
    if (ini == NumInit - 1) begin
      t = a[3:2] + a[5:4];
    end
    return t;
  endfunction

  // X bits in the model are don't-care
  function automatic bit matches_model(data_t exp, data_t got);
    for (int b = 0; b < DataWidth; b++) begin
      if (exp[b] !== 1'bx && exp[b] !== got[b]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic stop_on_error(string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  // ------------------------------
  // Checking
  // ------------------------------
  always @(posedge clk) begin : monitor
    tile_idx_t t;
    row_t      r;
    if (rst) begin
      if (rst_edges > 0) begin
        assert (resp_valid == '0) else stop_on_error("resp_valid_o high during reset");
      end
      rst_edges++;
      m_pend = '0;
      m_held = '0;
      cycle  = 0;
    end else begin
      for (int i = 0; i < NumInit; i++) begin
        if (m_held[i]) begin
          assert (resp_valid[i]) else stop_on_error("response dropped before handshake");
          assert (resp_rdata[i] === seen_rdata[i])
            else stop_on_error("response data changed under back-pressure");
          assert (!req_ready[i]) else stop_on_error("grant while a response is held");
          if (resp_ready[i]) begin
            m_held[i] = 1'b0;
          end
        end else if (m_pend[i]) begin
          assert (!req_ready[i]) else stop_on_error("grant while a read is outstanding");
          if (cycle == acc_cycle[i] + 2) begin
            assert (resp_valid[i]) else stop_on_error("response late after acceptance");
            assert (matches_model(exp_rdata[i], resp_rdata[i]))
              else stop_on_error($sformatf("initiator %0d read %h, expected %h",
                                           i, resp_rdata[i], exp_rdata[i]));
            seen_rdata[i] = resp_rdata[i];
            m_pend[i]     = 1'b0;
            m_held[i]     = !resp_ready[i];
          end else begin
            assert (!resp_valid[i]) else stop_on_error("response earlier than expected");
          end
        end else begin
          assert (!resp_valid[i]) else stop_on_error("response without a read");
        end
      end
      // Reads see the memory before this edge's writes
      for (int i = 0; i < NumInit; i++) begin
        if (req_valid[i] && req_ready[i] && req_op[i] == TCDM_READ) begin
          t            = model_tile(i, req_addr[i]);
          r            = req_addr[i][11:6];
          m_pend[i]    = 1'b1;
          acc_cycle[i] = cycle;
          exp_rdata[i] = model_mem[t][r];
        end
      end
      for (int i = 0; i < NumInit; i++) begin
        if (req_valid[i] && req_ready[i] && req_op[i] == TCDM_WRITE) begin
          t = model_tile(i, req_addr[i]);
          r = req_addr[i][11:6];
          for (int b = 0; b < StrbWidth; b++) begin
            if (req_strb[i][b]) begin
              model_mem[t][r][8*b +: 8] = req_wdata[i][8*b +: 8];
            end
          end
        end
      end
      cycle++;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  always @(posedge clk) begin : ready_drive
    logic [NumInit-1:0] mask;
    logic [31:0]        rnd;
    mask = stall_mask;
    #10;
    rnd = xorshift32();
    resp_ready = ~mask & (random_stall ? rnd[NumInit-1:0] : '1);
  end

  task automatic drive_req(int i, addr_t a, tcdm_op_e op, data_t d, strb_t s);
    req_addr[i]  = a;
    req_op[i]    = op;
    req_wdata[i] = d;
    req_strb[i]  = s;
    req_valid[i] = 1'b1;
  endtask

  task automatic wait_accept(int i);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = req_ready[i];
      n++;
      if (!done && n >= AcceptTimeout) begin
        stop_on_timeout($sformatf("request grant on initiator %0d", i));
      end
    end
    #10;
    req_valid[i] = 1'b0;
  endtask

  task automatic issue(int i, addr_t a, tcdm_op_e op, data_t d, strb_t s);
    drive_req(i, a, op, d, s);
    wait_accept(i);
  endtask

  task automatic wait_valid(int i);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #10;
      n++;
      if (!resp_valid[i] && n >= IdleTimeout) begin
        stop_on_timeout($sformatf("response on initiator %0d", i));
      end
    end while (!resp_valid[i]);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #10;
      n++;
      if ((m_pend | m_held) != '0 && n >= IdleTimeout) begin
        stop_on_timeout("all responses to drain");
      end
    end while ((m_pend | m_held) != '0);
  endtask

  task automatic run_traffic(int i);
    logic [31:0] r;
    tile_idx_t   tf;
    for (int n = 0; n < 40; n++) begin
      r = xorshift32();
      // Everyone lands on tile 1
      tf = (i == NumInit - 1) ? tile_idx_t'(2'd1 - r[9:8]) : tile_idx_t'(1);
      issue(i, make_addr({3'b000, r[7:5]}, r[9:8], tf),
            r[10] ? TCDM_WRITE : TCDM_READ, xorshift32(), r[14:11]);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    req_valid    = '0;
    resp_ready   = '1;
    stall_mask   = '0;
    random_stall = 1'b0;
    rst_edges    = 0;
    for (int i = 0; i < NumInit; i++) begin
      req_addr[i]  = '0;
      req_op[i]    = TCDM_READ;
      req_wdata[i] = '0;
      req_strb[i]  = '0;
    end
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;

    // Read after write, then a partial write on top
    issue(0, make_addr(6'd3, 2'd0, 2'd2), TCDM_WRITE, 32'h1234_5678, 4'hf);
    issue(0, make_addr(6'd3, 2'd0, 2'd2), TCDM_READ, '0, '0);
    wait_idle();
    issue(1, make_addr(6'd3, 2'd0, 2'd2), TCDM_WRITE, 32'haabb_ccdd, 4'b0101);
    issue(1, make_addr(6'd3, 2'd0, 2'd2), TCDM_READ, '0, '0);
    wait_idle();

    // DMA group 2, tile 3 ends up in tile 1
    issue(NumInit - 1, make_addr(6'd9, 2'd2, 2'd3), TCDM_WRITE, xorshift32(), 4'hf);
    issue(2, make_addr(6'd9, 2'd0, 2'd1), TCDM_READ, '0, '0);
    wait_idle();

    // Held response blocks a second request
    stall_mask[3] = 1'b1;
    issue(3, make_addr(6'd3, 2'd0, 2'd2), TCDM_READ, '0, '0);
    wait_valid(3);
    drive_req(3, make_addr(6'd4, 2'd0, 2'd0), TCDM_WRITE, 32'h0f0f_f0f0, 4'hf);
    repeat (10) @(posedge clk);
    #10;
    stall_mask[3] = 1'b0;
    wait_accept(3);
    wait_idle();

    random_stall = 1'b1;
    fork
      run_traffic(0);
      run_traffic(1);
      run_traffic(2);
      run_traffic(3);
      run_traffic(4);
    join
    random_stall = 1'b0;
    wait_idle();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
